/* design/cache_pkg.sv */
package cache_pkg;

    //////////////////////////////////////////////////
    // data widths
    //////////////////////////////////////////////////
    typedef logic [31:0] word_t;    // one data word
    typedef logic [31:0] addr_t;    // byte address
    typedef logic [3:0] mask_t;     // byte enables of a word

    localparam int LINE_WORDS = 4;  // words per line
    typedef word_t [LINE_WORDS-1:0] line_t;

    localparam int WORD_OFS_BITS = 2;   // word in line
    localparam int BYTE_OFS_BITS = 2;   // byte in word

    //////////////////////////////////////////////////
    // ways and replacement
    //////////////////////////////////////////////////
    localparam int NUM_WAYS = 4;    // tree compare assumes four
    typedef logic [1:0] way_t;

    typedef logic [3:0] age_t;
    localparam age_t LRU_MAX = 4'd15;  // age counters stop here

    // access size, 3 is illegal
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

endpackage

/* design/tag_store.sv */
`timescale 1ns/100ps
module tag_store #(
    parameter int NUM_SETS = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req,
    input  logic                            we,
    input  logic [$clog2(NUM_SETS)-1:0]     index,
    input  logic [$bits(cache_pkg::addr_t)-$clog2(NUM_SETS)-cache_pkg::WORD_OFS_BITS
                  -cache_pkg::BYTE_OFS_BITS-1:0] tag,
    input  cache_pkg::way_t                 cur_way,
    input  logic                            fill,
    input  logic [$clog2(NUM_SETS)-1:0]     fill_index,
    input  cache_pkg::way_t                 fill_way,
    input  logic [$bits(cache_pkg::addr_t)-$clog2(NUM_SETS)-cache_pkg::WORD_OFS_BITS
                  -cache_pkg::BYTE_OFS_BITS-1:0] fill_tag,
    input  logic                            fill_we,    // pending store rides with fill
    output logic                            hit,
    output cache_pkg::way_t                 hit_way,
    output cache_pkg::way_t                 free_way,
    output logic                            set_full,
    output logic [cache_pkg::NUM_WAYS-1:0]  way_dirty,
    output logic [$bits(cache_pkg::addr_t)-$clog2(NUM_SETS)-cache_pkg::WORD_OFS_BITS
                  -cache_pkg::BYTE_OFS_BITS-1:0] victim_tag
);
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = $bits(cache_pkg::addr_t) - IDX_W
                           - cache_pkg::WORD_OFS_BITS - cache_pkg::BYTE_OFS_BITS;

    logic [TAG_W-1:0]               tags  [NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::NUM_WAYS-1:0] valid [NUM_SETS];
    logic [cache_pkg::NUM_WAYS-1:0] dirty [NUM_SETS];   // only ever set on a valid way
    logic                           match;

    //////////////////////////////////////////////////
    // lookup where the lowest way wins
    //////////////////////////////////////////////////
    always_comb begin
        match    = 1'b0;
        hit_way  = '0;
        free_way = '0;
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (valid[index][w] && tags[index][w] == tag) begin
                match   = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
            if (!valid[index][w])
                free_way = cache_pkg::way_t'(w);   // first empty slot
        end
    end

    assign hit        = req & match;
    assign set_full   = &valid[index];
    assign way_dirty  = dirty[index];
    assign victim_tag = tags[index][cur_way];   // for write-back address

    //////////////////////////////////////////////////
    // state update
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (req && !match)
                dirty[index][cur_way] <= 1'b0;   // victim leaves with its copy in memory
            if (req && we && match) begin
                valid[index][cur_way] <= 1'b1;
                dirty[index][cur_way] <= 1'b1;
            end
            if (fill) begin
                valid[fill_index][fill_way] <= 1'b1;
                dirty[fill_index][fill_way] <= fill_we;  // store miss leaves line dirty
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill)
            tags[fill_index][fill_way] <= fill_tag;
    end

endmodule

/* design/lru_age.sv */
`timescale 1ns/100ps
module lru_age #(
    parameter int NUM_SETS = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,
    input  logic [$clog2(NUM_SETS)-1:0] index,
    input  logic                        evict,
    input  cache_pkg::way_t             cur_way,
    output cache_pkg::way_t             victim_way
);
    cache_pkg::age_t age [NUM_SETS][cache_pkg::NUM_WAYS];
    cache_pkg::way_t lo_win, hi_win;

    //////////////////////////////////////////////////
    // age counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++)
                for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
                    age[s][w] <= '0;
        end else if (req) begin
            for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                if (evict && cache_pkg::way_t'(w) == cur_way)
                    age[index][w] <= '0;                    // refilled way starts young
                else if (age[index][w] < cache_pkg::LRU_MAX)
                    age[index][w] <= age[index][w] + 1'b1;  // saturate
            end
        end
    end

    // tree compare, ties go to the lower way
    always_comb begin
        lo_win = (age[index][1] > age[index][0]) ? 2'd1 : 2'd0;
        hi_win = (age[index][3] > age[index][2]) ? 2'd3 : 2'd2;
        victim_way = (age[index][hi_win] > age[index][lo_win]) ? hi_win : lo_win;
    end

endmodule

/* design/miss_ctrl.sv */
`timescale 1ns/100ps
module miss_ctrl #(
    parameter int NUM_SETS = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req,
    input  logic                            we,
    input  cache_pkg::addr_t                addr,
    input  logic                            hit,
    input  cache_pkg::way_t                 hit_way,
    input  cache_pkg::way_t                 free_way,
    input  logic                            set_full,
    input  cache_pkg::way_t                 victim_way,
    input  logic [cache_pkg::NUM_WAYS-1:0]  way_dirty,
    input  logic [$bits(cache_pkg::addr_t)-$clog2(NUM_SETS)-cache_pkg::WORD_OFS_BITS
                  -cache_pkg::BYTE_OFS_BITS-1:0] victim_tag,
    input  cache_pkg::word_t                store_data,
    input  cache_pkg::mask_t                store_mask,
    output cache_pkg::way_t                 cur_way,
    output logic                            evict,
    output logic                            miss,
    output logic                            mem_rd,
    output cache_pkg::addr_t                mem_rd_addr,
    output logic                            mem_wr,
    output cache_pkg::addr_t                mem_wr_addr,
    output logic [$clog2(NUM_SETS)-1:0]     fill_index,
    output cache_pkg::way_t                 fill_way,
    output logic [$bits(cache_pkg::addr_t)-$clog2(NUM_SETS)-cache_pkg::WORD_OFS_BITS
                  -cache_pkg::BYTE_OFS_BITS-1:0] fill_tag,
    output logic                            fill_we,
    output logic [cache_pkg::WORD_OFS_BITS-1:0] fill_word,
    output cache_pkg::word_t                fill_data,
    output cache_pkg::mask_t                fill_mask
);
    localparam int LO_W  = cache_pkg::WORD_OFS_BITS + cache_pkg::BYTE_OFS_BITS;
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = $bits(cache_pkg::addr_t) - LO_W - IDX_W;

    // hit way first, then victim of a full set, then empty way
    assign cur_way = hit ? hit_way : (set_full ? victim_way : free_way);

    assign miss  = req & ~hit;
    assign evict = miss & set_full;

    //////////////////////////////////////////////////
    // line aligned memory strobes
    //////////////////////////////////////////////////
    assign mem_rd      = miss;
    assign mem_rd_addr = {addr[$bits(cache_pkg::addr_t)-1:LO_W], {LO_W{1'b0}}};
    assign mem_wr      = miss & way_dirty[cur_way];     // dirty implies valid
    assign mem_wr_addr = {victim_tag, addr[LO_W +: IDX_W], {LO_W{1'b0}}};

    // hold the miss for the fill cycle
    always_ff @(posedge clk) begin
        if (rst)
            fill_we <= 1'b0;
        else if (miss)
            fill_we <= we;
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            fill_index <= addr[LO_W +: IDX_W];
            fill_tag   <= addr[LO_W+IDX_W +: TAG_W];
            fill_way   <= cur_way;
            fill_word  <= addr[cache_pkg::BYTE_OFS_BITS +: cache_pkg::WORD_OFS_BITS];
            fill_data  <= store_data;   // merged at fill
            fill_mask  <= store_mask;
        end
    end

endmodule

/* design/line_store.sv */
`timescale 1ns/100ps
module line_store #(
    parameter int NUM_SETS = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                req,
    input  logic                                we,
    input  logic                                hit,
    input  logic [$clog2(NUM_SETS)-1:0]         index,
    input  logic [cache_pkg::WORD_OFS_BITS-1:0] word_ofs,
    input  cache_pkg::way_t                     cur_way,
    input  cache_pkg::word_t                    store_data,
    input  cache_pkg::mask_t                    store_mask,
    input  logic                                fill,
    input  cache_pkg::line_t                    fill_line,
    input  logic [$clog2(NUM_SETS)-1:0]         fill_index,
    input  cache_pkg::way_t                     fill_way,
    input  logic                                fill_we,
    input  logic [cache_pkg::WORD_OFS_BITS-1:0] fill_word,
    input  cache_pkg::word_t                    fill_data,
    input  cache_pkg::mask_t                    fill_mask,
    output cache_pkg::line_t                    wb_line,
    output cache_pkg::word_t                    load_word,
    output logic                                load_valid
);
    cache_pkg::line_t lines [NUM_SETS][cache_pkg::NUM_WAYS];
    cache_pkg::line_t merged;
    logic             hit_ld, miss_ld;

    assign hit_ld  = req & ~we & hit;
    assign miss_ld = fill & ~fill_we;
    assign wb_line = lines[index][cur_way];     // victim, read in the miss cycle

    // incoming line with pending store bytes on top
    always_comb begin
        merged = fill_line;
        for (int b = 0; b < $bits(cache_pkg::mask_t); b++)
            if (fill_we && fill_mask[b])
                merged[fill_word][8*b +: 8] = fill_data[8*b +: 8];
    end

    //////////////////////////////////////////////////
    // array writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (req && we && hit)
            for (int b = 0; b < $bits(cache_pkg::mask_t); b++)
                if (store_mask[b])
                    lines[index][cur_way][word_ofs][8*b +: 8] <= store_data[8*b +: 8];
        if (fill)
            lines[fill_index][fill_way] <= merged;
    end

    // load word, hit or from the fill
    always_ff @(posedge clk) begin
        if (rst) begin
            load_word  <= '0;
            load_valid <= 1'b0;
        end else begin
            load_valid <= hit_ld | miss_ld;
            if (hit_ld)
                load_word <= lines[index][cur_way][word_ofs];
            else if (miss_ld)
                load_word <= fill_line[fill_word];
        end
    end

endmodule

/* design/lane_align.sv */
`timescale 1ns/100ps
module lane_align (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                req,
    input  logic                                we,
    input  cache_pkg::mem_size_e                size,
    input  logic                                sign,       // high = unsigned
    input  logic [cache_pkg::BYTE_OFS_BITS-1:0] byte_ofs,
    input  cache_pkg::word_t                    wdata,
    input  cache_pkg::word_t                    load_word,
    input  logic                                load_valid,
    output cache_pkg::word_t                    store_data,
    output cache_pkg::mask_t                    store_mask,
    output cache_pkg::word_t                    rdata,
    output logic                                rd_valid
);
    cache_pkg::mem_size_e                saved_size;
    logic                                saved_sign;
    logic [cache_pkg::BYTE_OFS_BITS-1:0] saved_ofs;
    cache_pkg::word_t                    shifted;

    //////////////////////////////////////////////////
    // store lanes
    //////////////////////////////////////////////////
    always_comb begin
        store_data = wdata << {byte_ofs, 3'b000};
        case (size)
            cache_pkg::SIZE_BYTE: store_mask = 4'b0001 << byte_ofs;
            cache_pkg::SIZE_HALF: store_mask = (byte_ofs == 2'd3) ? 4'b0000 : 4'b0011 << byte_ofs;
            cache_pkg::SIZE_WORD: store_mask = (byte_ofs == 2'd0) ? 4'b1111 : 4'b0000;
            default:              store_mask = 4'b0000;   // size 3
        endcase
    end

    // load fields, valid until the load word shows up
    always_ff @(posedge clk) begin
        if (rst) begin
            saved_size <= cache_pkg::SIZE_BYTE;
            saved_sign <= 1'b0;
            saved_ofs  <= '0;
        end else if (req && !we) begin
            saved_size <= size;
            saved_sign <= sign;
            saved_ofs  <= byte_ofs;
        end
    end

    //////////////////////////////////////////////////
    // load extract and extend
    //////////////////////////////////////////////////
    always_comb begin
        shifted = load_word >> {saved_ofs, 3'b000};
        case (saved_size)
            cache_pkg::SIZE_BYTE:
                rdata = saved_sign ? {24'd0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
            cache_pkg::SIZE_HALF:
                if (saved_ofs == 2'd3)
                    rdata = '0;     // half would cross the word
                else
                    rdata = saved_sign ? {16'd0, shifted[15:0]}
                                       : {{16{shifted[15]}}, shifted[15:0]};
            cache_pkg::SIZE_WORD:
                rdata = (saved_ofs == 2'd0) ? load_word : '0;
            default:
                rdata = '0;
        endcase
    end

    assign rd_valid = load_valid;   // already registered in line_store

endmodule

/* design/dcache_top.sv */
`timescale 1ns/100ps
module dcache_top #(
    parameter int NUM_SETS = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  logic                  we,
    input  cache_pkg::addr_t      addr,
    input  cache_pkg::word_t      wdata,
    input  cache_pkg::mem_size_e  size,
    input  logic                  sign,         // high = unsigned
    output logic                  hit,
    output logic                  miss,
    output cache_pkg::word_t      rdata,
    output logic                  rd_valid,
    output logic                  mem_rd,
    output cache_pkg::addr_t      mem_rd_addr,
    output logic                  mem_wr,
    output cache_pkg::addr_t      mem_wr_addr,
    output cache_pkg::line_t      wb_line,
    input  logic                  fill,         // one cycle after mem_rd
    input  cache_pkg::line_t      fill_line
);
    localparam int LO_W  = cache_pkg::WORD_OFS_BITS + cache_pkg::BYTE_OFS_BITS;
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = $bits(cache_pkg::addr_t) - LO_W - IDX_W;

    // address fields
    wire [IDX_W-1:0]                    index    = addr[LO_W +: IDX_W];
    wire [TAG_W-1:0]                    tag      = addr[LO_W+IDX_W +: TAG_W];
    wire [cache_pkg::WORD_OFS_BITS-1:0] word_ofs = addr[cache_pkg::BYTE_OFS_BITS +: 2];
    wire [cache_pkg::BYTE_OFS_BITS-1:0] byte_ofs = addr[cache_pkg::BYTE_OFS_BITS-1:0];

    cache_pkg::way_t  hit_way, free_way, victim_way, cur_way, fill_way;
    logic             set_full, evict, fill_we, load_valid;
    logic [cache_pkg::NUM_WAYS-1:0]     way_dirty;
    logic [TAG_W-1:0]                   victim_tag, fill_tag;
    logic [IDX_W-1:0]                   fill_index;
    logic [cache_pkg::WORD_OFS_BITS-1:0] fill_word;
    cache_pkg::word_t store_data, fill_data, load_word;
    cache_pkg::mask_t store_mask, fill_mask;

    tag_store #(.NUM_SETS(NUM_SETS)) u_tag (
        .clk, .rst, .req, .we, .index, .tag, .cur_way,
        .fill, .fill_index, .fill_way, .fill_tag, .fill_we,
        .hit, .hit_way, .free_way, .set_full, .way_dirty, .victim_tag
    );

    lru_age #(.NUM_SETS(NUM_SETS)) u_lru (
        .clk, .rst, .req, .index, .evict, .cur_way, .victim_way
    );

    miss_ctrl #(.NUM_SETS(NUM_SETS)) u_miss (
        .clk, .rst, .req, .we, .addr, .hit, .hit_way, .free_way, .set_full,
        .victim_way, .way_dirty, .victim_tag, .store_data, .store_mask,
        .cur_way, .evict, .miss, .mem_rd, .mem_rd_addr, .mem_wr, .mem_wr_addr,
        .fill_index, .fill_way, .fill_tag, .fill_we, .fill_word, .fill_data, .fill_mask
    );

    line_store #(.NUM_SETS(NUM_SETS)) u_line (
        .clk, .rst, .req, .we, .hit, .index, .word_ofs, .cur_way,
        .store_data, .store_mask, .fill, .fill_line, .fill_index, .fill_way,
        .fill_we, .fill_word, .fill_data, .fill_mask,
        .wb_line, .load_word, .load_valid
    );

    lane_align u_lane (
        .clk, .rst, .req, .we, .size, .sign, .byte_ofs, .wdata,
        .load_word, .load_valid, .store_data, .store_mask, .rdata, .rd_valid
    );

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/100ps
module tb_clock #(
    parameter int PERIOD     = 40,     // ns
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset drops just after an edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

/* dv/tb_model.svh */
//////////////////////////////////////////////////
// reference cache and memory state
//////////////////////////////////////////////////
localparam int M_SETS    = 4;
localparam int M_WAYS    = cache_pkg::NUM_WAYS;
localparam int MEM_WORDS = 128;                    // 8 tags x 4 sets x 4 words
localparam cache_pkg::word_t FILL_KEY = 32'h5ac3_1e96;

logic [25:0]       m_tag   [M_SETS][M_WAYS];      // addr[31:6]
logic              m_valid [M_SETS][M_WAYS];
logic              m_dirty [M_SETS][M_WAYS];
cache_pkg::age_t   m_age   [M_SETS][M_WAYS];
cache_pkg::line_t  m_line  [M_SETS][M_WAYS];
cache_pkg::word_t  mem     [MEM_WORDS];           // backing memory, word addressed
logic [31:0]       lfsr;

// galois lfsr, one step per bit
function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
        r = {r[30:0], lfsr_bit()};
    return r;
endfunction

task automatic mem_init();
    for (int i = 0; i < MEM_WORDS; i++)
        mem[i] = (32'(i) << 2) ^ FILL_KEY;     // byte address of the word, scrambled
endtask

function automatic cache_pkg::line_t mem_line(input cache_pkg::addr_t a);
    cache_pkg::line_t l;
    for (int w = 0; w < cache_pkg::LINE_WORDS; w++)
        l[w] = mem[{a[8:4], 2'(w)}];
    return l;
endfunction

task automatic model_reset();
    for (int s = 0; s < M_SETS; s++)
        for (int w = 0; w < M_WAYS; w++) begin
            m_tag[s][w]   = '0;
            m_valid[s][w] = 1'b0;
            m_dirty[s][w] = 1'b0;
            m_age[s][w]   = '0;
            m_line[s][w]  = '0;
        end
endtask

task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
        $display("Error: %s got %0h expected %0h", name, got, exp);
        $display("RESULT: FAIL");
        $fatal(1);
    end
endtask

//////////////////////////////////////////////////
// one access: lookup, way choice, ages, data
//////////////////////////////////////////////////
task automatic model_access(
    input  logic                 wr,
    input  cache_pkg::addr_t     a,
    input  cache_pkg::word_t     wd,
    input  cache_pkg::mem_size_e sz,
    input  logic                 sg,        // high = zero extend
    output logic                 hit_o,
    output logic                 wb_o,
    output cache_pkg::addr_t     wb_addr_o,
    output cache_pkg::line_t     wb_line_o,
    output cache_pkg::word_t     load_o
);
    int               idx, wofs, bofs, nb, way, free, lo, hi;
    logic             full;
    cache_pkg::line_t l;
    idx   = int'(a[5:4]);
    wofs  = int'(a[3:2]);
    bofs  = int'(a[1:0]);
    nb    = (sz == cache_pkg::SIZE_BYTE) ? 1 : (sz == cache_pkg::SIZE_HALF) ? 2 : 4;
    hit_o = 1'b0;
    way   = 0;
    full  = 1'b1;
    free  = 0;
    for (int w = M_WAYS - 1; w >= 0; w--) begin     // walk down, lowest match sticks
        if (m_valid[idx][w] && m_tag[idx][w] == a[31:6]) begin
            hit_o = 1'b1;
            way   = w;
        end
        if (!m_valid[idx][w]) begin
            full = 1'b0;
            free = w;
        end
    end
    lo = (m_age[idx][1] > m_age[idx][0]) ? 1 : 0;   // older of each pair, ties low
    hi = (m_age[idx][3] > m_age[idx][2]) ? 3 : 2;
    if (!hit_o)
        way = !full ? free : (m_age[idx][hi] > m_age[idx][lo]) ? hi : lo;
    wb_o      = !hit_o && m_valid[idx][way] && m_dirty[idx][way];
    wb_addr_o = {m_tag[idx][way], 2'(idx), 4'b0000};
    wb_line_o = m_line[idx][way];
    for (int w = 0; w < M_WAYS; w++) begin
        if (!hit_o && full && w == way)
            m_age[idx][w] = '0;                         // evicted way restarts
        else if (m_age[idx][w] < cache_pkg::LRU_MAX)
            m_age[idx][w] = m_age[idx][w] + 4'd1;
    end
    l = hit_o ? m_line[idx][way] : mem_line(a);
    if (wr)
        for (int b = 0; b < nb; b++)
            l[wofs][8*(bofs+b) +: 8] = wd[8*b +: 8];    // only the enabled bytes
    load_o = '0;
    for (int b = 0; b < nb; b++)
        load_o[8*b +: 8] = l[wofs][8*(bofs+b) +: 8];
    if (!sg && load_o[8*nb-1])
        for (int b = nb; b < 4; b++)
            load_o[8*b +: 8] = 8'hff;                   // sign fill
    m_line[idx][way]  = l;
    m_tag[idx][way]   = a[31:6];
    m_valid[idx][way] = 1'b1;
    m_dirty[idx][way] = (hit_o && m_dirty[idx][way]) || wr;
endtask

/* dv/tb_top.sv */
`timescale 1ns/100ps
module tb_top;

    localparam int NUM_REQ    = 2000;
    localparam int RST_CYCLES = 16;
    localparam int TIMEOUT    = 3 * NUM_REQ + RST_CYCLES;   // a miss costs two cycles

    logic                 clk, rst;
    logic                 req, we, sign, fill;
    cache_pkg::addr_t     addr, mem_rd_addr, mem_wr_addr;
    cache_pkg::word_t     wdata, rdata;
    cache_pkg::mem_size_e size;
    cache_pkg::line_t     fill_line, wb_line;
    logic                 hit, miss, rd_valid, mem_rd, mem_wr;
    logic                 due_v [2];    // load result owed this cycle / next cycle
    cache_pkg::word_t     due_d [2];
    int                   cycles;

    `include "tb_model.svh"

    tb_clock #(.PERIOD(40), .RST_CYCLES(RST_CYCLES)) u_clock (.clk, .rst);

    dcache_top #(.NUM_SETS(M_SETS)) dut (.*);

    //////////////////////////////////////////////////
    // memory responder, fill one cycle after mem_rd
    //////////////////////////////////////////////////
    initial begin
        logic             pend;
        cache_pkg::addr_t pend_addr;
        mem_init();
        fill      = 1'b0;
        fill_line = '0;
        forever begin
            @(negedge clk);
            pend      = mem_rd;
            pend_addr = mem_rd_addr;
            if (mem_wr)
                for (int w = 0; w < cache_pkg::LINE_WORDS; w++)
                    mem[{mem_wr_addr[8:4], 2'(w)}] = wb_line[w];   // victim back
            @(posedge clk);
            #2;
            fill      = pend;
            fill_line = pend ? mem_line(pend_addr) : '0;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT);
        $display("RESULT: FAIL");
        $fatal(1);
    end

    // drive one cycle, then check the DUT against the model mid-cycle
    task automatic run_cycle(input logic r, input logic w, input cache_pkg::addr_t a,
                             input cache_pkg::word_t d, input cache_pkg::mem_size_e sz,
                             input logic sg, output logic missed);
        logic             e_hit, e_wb;
        cache_pkg::addr_t e_wa;
        cache_pkg::line_t e_wl;
        cache_pkg::word_t e_ld;
        @(posedge clk);
        #2;
        req   = r;
        we    = w;
        addr  = a;
        wdata = d;
        size  = sz;
        sign  = sg;
        e_hit = 1'b0;
        e_wb  = 1'b0;
        e_wa  = '0;
        e_wl  = '0;
        e_ld  = '0;
        if (r)
            model_access(w, a, d, sz, sg, e_hit, e_wb, e_wa, e_wl, e_ld);
        missed = r && !e_hit;
        @(negedge clk);
        compare("hit", hit, e_hit);
        compare("miss", miss, missed);
        compare("mem_rd", mem_rd, missed);
        if (missed)
            compare("mem_rd_addr", mem_rd_addr, {a[31:4], 4'b0000});
        compare("mem_wr", mem_wr, e_wb);
        if (e_wb) begin
            compare("mem_wr_addr", mem_wr_addr, e_wa);
            compare("wb_line", wb_line, e_wl);
        end
        compare("rd_valid", rd_valid, due_v[0]);
        if (due_v[0])
            compare("rdata", rdata, due_d[0]);
        due_v[0] = due_v[1];            // age the response slots
        due_d[0] = due_d[1];
        due_v[1] = 1'b0;
        if (r && !w) begin
            due_v[missed] = 1'b1;       // hit next cycle, miss one later
            due_d[missed] = e_ld;
        end
    endtask

    task automatic idle_cycle();
        logic missed;
        run_cycle(1'b0, 1'b0, '0, '0, cache_pkg::SIZE_BYTE, 1'b0, missed);
    endtask

    // 8 tags, all sets and words, legal size and offset pairs
    task automatic random_request(output logic missed);
        logic                 w, sg;
        logic [1:0]           ofs;
        cache_pkg::mem_size_e sz;
        cache_pkg::addr_t     a;
        cache_pkg::word_t     d;
        w  = lfsr_bit();
        sg = lfsr_bit();
        case (rand_bits(2))
            0:       sz = cache_pkg::SIZE_BYTE;
            1:       sz = cache_pkg::SIZE_HALF;
            default: sz = cache_pkg::SIZE_WORD;
        endcase
        ofs = 2'(rand_bits(2));
        if (sz == cache_pkg::SIZE_WORD)
            ofs = 2'd0;
        else if (sz == cache_pkg::SIZE_HALF && ofs == 2'd3)
            ofs = 2'd2;                 // half must stay inside the word
        a      = '0;
        a[8:6] = 3'(rand_bits(3));      // tag
        a[5:4] = 2'(rand_bits(2));      // set
        a[3:2] = 2'(rand_bits(2));      // word
        a[1:0] = ofs;
        d      = rand_bits(32);
        run_cycle(1'b1, w, a, d, sz, sg, missed);
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        logic missed;
        req      = 1'b0;
        we       = 1'b0;
        addr     = '0;
        wdata    = '0;
        size     = cache_pkg::SIZE_BYTE;
        sign     = 1'b0;
        due_v[0] = 1'b0;
        due_v[1] = 1'b0;
        due_d[0] = '0;
        due_d[1] = '0;
        lfsr     = 32'h2a4a_8802;
        model_reset();
        @(negedge rst);
        repeat (4) idle_cycle();        // quiet bus straight after reset
        for (int n = 0; n < NUM_REQ; n++) begin
            random_request(missed);
            if (missed)
                idle_cycle();           // fill cycle
        end
        repeat (2) idle_cycle();        // last load response
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+dv
design/cache_pkg.sv
design/tag_store.sv
design/lru_age.sv
design/miss_ctrl.sv
design/line_store.sv
design/lane_align.sv
design/dcache_top.sv
dv/tb_clock.sv
dv/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= RESULT: PASS

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard design/*.sv dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qFx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
